/* source/req_pkg.sv */
package req_pkg;

    // Request field widths.
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Request address. The low bits pick the bank.
    typedef logic [ADDR_W-1:0] req_addr_t;

    // Request payload.
    typedef logic [DATA_W-1:0] req_data_t;

    // One queue entry holds the address above the data.
    localparam int ENTRY_W = ADDR_W + DATA_W;

endpackage

/* source/bank_pkg.sv */
package bank_pkg;

    // Bank organization.
    localparam int NUM_BANKS  = 4;
    localparam int BANK_IDX_W = $clog2(NUM_BANKS);
    localparam int MAX_DEPTH  = 16;

    // Fill count must reach MAX_DEPTH itself.
    localparam int OCC_W  = $clog2(MAX_DEPTH + 1);
    localparam int DROP_W = 16;

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [OCC_W-1:0]      occupancy_t;

    // Saturating drop counter.
    typedef logic [DROP_W-1:0]     drop_count_t;

endpackage

/* source/bank_router.sv */
`timescale 1ns/1ps

module bank_router #(
    parameter int DATAW = 48
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  req_pkg::req_addr_t                in_addr,
    input  req_pkg::req_data_t                in_data,
    input  logic [bank_pkg::NUM_BANKS-1:0]    full,
    output logic [bank_pkg::NUM_BANKS-1:0]    push,
    output logic [DATAW-1:0]                  entry,
    output bank_pkg::drop_count_t             drop_count
);

    bank_pkg::bank_idx_t bank;
    logic                rejected;

    // Bank comes straight from the low address bits.
    assign bank = in_addr[bank_pkg::BANK_IDX_W-1:0];

    // Every queue sees the same entry; only the pushed one stores it.
    assign entry = {in_addr, in_data};

    assign rejected = in_valid && full[bank];

    always_comb begin
        push = '0;
        if (in_valid && !full[bank]) begin
            push[bank] = 1'b1;
        end
    end

    // Counts requests lost to a full bank, sticks at all ones.
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (rejected && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

/* source/generic_queue.sv */
`timescale 1ns/1ps

module generic_queue #(
    parameter int DATAW           = 48,
    parameter int SIZE            = 8,
    parameter int BUFFERED_OUTPUT = 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic                 pop,
    input  logic [DATAW-1:0]     data_in,
    output logic [DATAW-1:0]     data_out,
    output logic                 empty,
    output logic                 full,
    output bank_pkg::occupancy_t size
);

    localparam int ADDRW = $clog2(SIZE);

    typedef logic [ADDRW-1:0] ptr_t;

    localparam ptr_t LAST = ptr_t'(SIZE - 1);

    logic [DATAW-1:0]     mem [SIZE];
    bank_pkg::occupancy_t size_r;

    // Pointer step with wrap, so SIZE need not be a power of two.
    function automatic ptr_t wrap_inc(ptr_t p);
        return (p == LAST) ? '0 : p + 1'b1;
    endfunction

    // Fill count is the same in both output modes.
    always_ff @(posedge clk) begin
        if (reset) begin
            size_r <= '0;
        end else if (push && !pop) begin
            size_r <= size_r + 1'b1;
        end else if (pop && !push) begin
            size_r <= size_r - 1'b1;
        end
    end

    assign size = size_r;

    if (BUFFERED_OUTPUT == 0) begin : g_plain

        // Extra phase bit tells full from empty.
        logic [ADDRW:0] wr_ptr_r;
        logic [ADDRW:0] rd_ptr_r;
        ptr_t           wr_addr;
        ptr_t           rd_addr;

        assign wr_addr = wr_ptr_r[ADDRW-1:0];
        assign rd_addr = rd_ptr_r[ADDRW-1:0];

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr_r <= '0;
                rd_ptr_r <= '0;
            end else begin
                if (push) begin
                    wr_ptr_r <= {wr_ptr_r[ADDRW] ^ (wr_addr == LAST), wrap_inc(wr_addr)};
                end
                if (pop) begin
                    rd_ptr_r <= {rd_ptr_r[ADDRW] ^ (rd_addr == LAST), wrap_inc(rd_addr)};
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_addr] <= data_in;
            end
        end

        assign data_out = mem[rd_addr];
        assign empty    = (wr_ptr_r == rd_ptr_r);
        assign full     = (wr_addr == rd_addr) && (wr_ptr_r[ADDRW] != rd_ptr_r[ADDRW]);

    end else begin : g_buffered

        ptr_t             wr_ptr_r;
        ptr_t             rd_ptr_r;
        ptr_t             rd_next_ptr_r;
        logic             empty_r;
        logic             full_r;
        logic             bypass_r;
        logic [DATAW-1:0] head_r;
        logic [DATAW-1:0] curr_r;

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr_r      <= '0;
                rd_ptr_r      <= '0;
                rd_next_ptr_r <= ptr_t'(1);
                empty_r       <= 1'b1;
                full_r        <= 1'b0;
                bypass_r      <= 1'b0;
            end else begin
                if (push) begin
                    wr_ptr_r <= wrap_inc(wr_ptr_r);
                end

                // Read-ahead pointer stays one slot past the head.
                if (pop) begin
                    rd_ptr_r      <= rd_next_ptr_r;
                    rd_next_ptr_r <= wrap_inc(rd_next_ptr_r);
                end

                if (push && !pop) begin
                    empty_r <= 1'b0;
                    if (size_r == bank_pkg::occupancy_t'(SIZE - 1)) begin
                        full_r <= 1'b1;
                    end
                end else if (pop && !push) begin
                    full_r <= 1'b0;
                    if (size_r == bank_pkg::occupancy_t'(1)) begin
                        empty_r <= 1'b1;
                    end
                end

                // Memory read lags the write, so forward the fresh word.
                bypass_r <= push && (empty_r || (pop && (size_r == bank_pkg::occupancy_t'(1))));
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr_r] <= data_in;
            end
            curr_r <= data_in;
            head_r <= mem[pop ? rd_next_ptr_r : rd_ptr_r];
        end

        assign data_out = bypass_r ? curr_r : head_r;
        assign empty    = empty_r;
        assign full     = full_r;

    end

endmodule

/* source/rr_drain_arbiter.sv */
`timescale 1ns/1ps

module rr_drain_arbiter #(
    parameter int DATAW = 48
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hold,
    input  logic [bank_pkg::NUM_BANKS-1:0]      empty,
    input  logic [bank_pkg::NUM_BANKS*DATAW-1:0] head_data,
    output logic [bank_pkg::NUM_BANKS-1:0]      pop,
    output logic                                out_valid,
    output bank_pkg::bank_idx_t                 out_bank,
    output req_pkg::req_addr_t                  out_addr,
    output req_pkg::req_data_t                  out_data
);

    localparam int ADDR_W = $bits(req_pkg::req_addr_t);
    localparam int DATA_W = $bits(req_pkg::req_data_t);

    bank_pkg::bank_idx_t last_r;
    bank_pkg::bank_idx_t sel;
    logic                found;
    logic                grant;
    logic [DATAW-1:0]    sel_entry;

    // First non-empty bank after the one served last, wrapping.
    always_comb begin
        bank_pkg::bank_idx_t idx;
        sel   = last_r;
        found = 1'b0;
        for (int i = 1; i <= bank_pkg::NUM_BANKS; i++) begin
            idx = bank_pkg::bank_idx_t'(int'(last_r) + i);
            if (!found && !empty[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign grant = found && !hold;

    always_comb begin
        pop = '0;
        if (grant) begin
            pop[sel] = 1'b1;
        end
    end

    assign sel_entry = head_data[int'(sel)*DATAW +: DATAW];

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            last_r    <= '0;
        end else begin
            out_valid <= grant;
            if (grant) begin
                last_r <= sel;
            end
        end
    end

    // Output fields only matter while out_valid is high.
    always_ff @(posedge clk) begin
        if (grant) begin
            out_bank <= sel;
            out_addr <= sel_entry[DATAW-1 -: ADDR_W];
            out_data <= sel_entry[DATA_W-1:0];
        end
    end

endmodule

/* source/bank_queue_top.sv */
`timescale 1ns/1ps

module bank_queue_top #(
    parameter int DEPTH           = 8,
    parameter int BUFFERED_OUTPUT = 1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  req_pkg::req_addr_t      in_addr,
    input  req_pkg::req_data_t      in_data,
    input  logic                    hold,
    output logic                    out_valid,
    output bank_pkg::bank_idx_t     out_bank,
    output req_pkg::req_addr_t      out_addr,
    output req_pkg::req_data_t      out_data,
    output logic [bank_pkg::NUM_BANKS*bank_pkg::OCC_W-1:0] occupancy,
    output bank_pkg::drop_count_t   drop_count
);

    localparam int NB    = bank_pkg::NUM_BANKS;
    localparam int DATAW = req_pkg::ENTRY_W;

    logic [NB-1:0]       push;
    logic [NB-1:0]       pop;
    logic [NB-1:0]       empty;
    logic [NB-1:0]       full;
    logic [DATAW-1:0]    entry;
    logic [NB*DATAW-1:0] head_data;

    bank_router #(
        .DATAW (DATAW)
    ) u_bank_router (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .full       (full),
        .push       (push),
        .entry      (entry),
        .drop_count (drop_count)
    );

    for (genvar b = 0; b < NB; b++) begin : g_bank
        generic_queue #(
            .DATAW           (DATAW),
            .SIZE            (DEPTH),
            .BUFFERED_OUTPUT (BUFFERED_OUTPUT)
        ) u_queue (
            .clk      (clk),
            .reset    (reset),
            .push     (push[b]),
            .pop      (pop[b]),
            .data_in  (entry),
            .data_out (head_data[b*DATAW +: DATAW]),
            .empty    (empty[b]),
            .full     (full[b]),
            .size     (occupancy[b*bank_pkg::OCC_W +: bank_pkg::OCC_W])
        );
    end

    rr_drain_arbiter #(
        .DATAW (DATAW)
    ) u_rr_drain_arbiter (
        .clk       (clk),
        .reset     (reset),
        .hold      (hold),
        .empty     (empty),
        .head_data (head_data),
        .pop       (pop),
        .out_valid (out_valid),
        .out_bank  (out_bank),
        .out_addr  (out_addr),
        .out_data  (out_data)
    );

endmodule

/* tb/bank_queue_tb.sv */
`timescale 1ns/1ps

module bank_queue_tb;

    localparam int DEPTH = 8;
    localparam int NB    = bank_pkg::NUM_BANKS;
    localparam int OCCW  = bank_pkg::OCC_W;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    req_pkg::req_addr_t    in_addr;
    req_pkg::req_data_t    in_data;
    logic                  hold;
    logic                  out_valid;
    bank_pkg::bank_idx_t   out_bank;
    req_pkg::req_addr_t    out_addr;
    req_pkg::req_data_t    out_data;
    logic [NB*OCCW-1:0]    occupancy;
    bank_pkg::drop_count_t drop_count;
    bank_pkg::bank_idx_t   out_addr_bank;

    // Reference queues, one per bank, holding {addr, data}.
    logic [req_pkg::ENTRY_W-1:0] model_q [NB][$];
    int                          order_q [$];
    int                          model_drops;
    int                          out_count;
    int                          errors;
    int                          seed;

    bank_queue_top #(.DEPTH(DEPTH), .BUFFERED_OUTPUT(1)) u_bank_queue_top (.*);

    always #4 clk = ~clk;

    assign out_addr_bank = out_addr[bank_pkg::BANK_IDX_W-1:0];

    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_bank == out_addr_bank)
    else begin
        errors++;
        $display("MISMATCH bank_select expected %0d actual %0d",
                 $sampled(out_addr_bank), $sampled(out_bank));
    end

    // A held cycle pops nothing, so no strobe follows it.
    assert property (@(posedge clk) disable iff (reset) hold |=> !out_valid)
    else begin
        errors++;
        $display("MISMATCH hold_stall expected 0 actual %0d", $sampled(out_valid));
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual)
        else begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_occupancy(input string name, input int bank, input int expected);
        check_value(name, 64'(expected), 64'(occupancy[bank*OCCW +: OCCW]));
    endtask

    function automatic int model_total();
        int total = 0;
        for (int b = 0; b < NB; b++) begin
            total += model_q[b].size();
        end
        return total;
    endfunction

    function automatic req_pkg::req_addr_t make_addr(input int bank);
        req_pkg::req_addr_t addr;
        addr = req_pkg::req_addr_t'($random(seed));
        addr[bank_pkg::BANK_IDX_W-1:0] = bank_pkg::bank_idx_t'(bank);
        return addr;
    endfunction

    // Compares a leaving request with the oldest entry of its bank.
    task automatic check_output();
        logic [req_pkg::ENTRY_W-1:0] expected;
        if (out_valid) begin
            out_count++;
            order_q.push_back(int'(out_bank));
            if (model_q[out_bank].size() == 0) begin
                errors++;
                $display("Bank %0d sent a request that was never accepted", out_bank);
            end else begin
                expected = model_q[out_bank].pop_front();
                check_value("bank_order", 64'(expected), 64'({out_addr, out_data}));
            end
        end
    endtask

    // One cycle. A request is taken only while its bank holds fewer than DEPTH.
    task automatic step(input logic valid, input req_pkg::req_addr_t addr,
                        input req_pkg::req_data_t data);
        bank_pkg::bank_idx_t b;
        @(negedge clk);
        check_output();
        in_valid = valid;
        in_addr  = addr;
        in_data  = data;
        b        = addr[bank_pkg::BANK_IDX_W-1:0];
        if (valid && model_q[b].size() < DEPTH) begin
            model_q[b].push_back({addr, data});
        end else if (valid) begin
            model_drops++;
        end
    endtask

    task automatic wait_outputs(input int count);
        int cycles = 0;
        while (order_q.size() < count && cycles < 200) begin
            step(1'b0, '0, '0);
            cycles++;
        end
        if (order_q.size() < count) begin
            errors++;
            $display("Timed out waiting for %0d output strobes", count);
        end
    endtask

    task automatic drain();
        int cycles = 0;
        hold = 1'b0;
        while (model_total() != 0 && cycles < 500) begin
            step(1'b0, '0, '0);
            cycles++;
        end
        if (model_total() != 0) begin
            errors++;
            $display("Timed out draining, %0d requests still queued", model_total());
        end
        // Nothing more may leave.
        repeat (3) step(1'b0, '0, '0);
    endtask

    initial begin
        int drops_before;
        int outs_before;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_addr     = '0;
        in_data     = '0;
        hold        = 1'b0;
        errors      = 0;
        model_drops = 0;
        out_count   = 0;
        seed        = 40;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("reset_out_valid", 64'd0, 64'(out_valid));
        check_value("reset_drop_count", 64'd0, 64'(drop_count));
        for (int b = 0; b < NB; b++) begin
            check_occupancy("reset_occupancy", b, 0);
        end

        // Pointer starts at bank 0, so the search serves bank 1 first.
        hold = 1'b1;
        for (int k = 0; k < 2 * NB; k++) begin
            step(1'b1, make_addr(k % NB), req_pkg::req_data_t'($random(seed)));
        end
        step(1'b0, '0, '0);
        order_q.delete();
        hold = 1'b0;
        wait_outputs(2 * NB);
        for (int k = 0; k < 2 * NB && k < order_q.size(); k++) begin
            check_value("round_robin", 64'((k + 1) % NB), 64'(order_q[k]));
        end

        drops_before = model_drops;
        hold         = 1'b1;
        for (int k = 0; k < DEPTH + 3; k++) begin
            step(1'b1, make_addr(2), req_pkg::req_data_t'($random(seed)));
        end
        step(1'b0, '0, '0);
        check_value("overflow_drops", 64'(drops_before + 3), 64'(drop_count));
        check_occupancy("overflow_occupancy", 2, DEPTH);
        outs_before = out_count;
        drain();
        check_value("overflow_outputs", 64'(DEPTH), 64'(out_count - outs_before));

        drops_before = model_drops;
        outs_before  = out_count;
        for (int k = 0; k < 400; k++) begin
            if (($random(seed) % 6) == 0) begin
                hold = !hold;
            end
            step(1'b1, make_addr($random(seed) & 3), req_pkg::req_data_t'($random(seed)));
            if (($random(seed) % 3) == 0) begin
                step(1'b0, '0, '0);
            end
        end
        drain();
        check_value("random_outputs", 64'(400 - (model_drops - drops_before)),
                    64'(out_count - outs_before));
        for (int b = 0; b < NB; b++) begin
            check_occupancy("random_occupancy", b, 0);
        end
        check_value("drop_total", 64'(model_drops), 64'(drop_count));

        $display("Errors: %0d, outputs: %0d, drops: %0d", errors, out_count, drop_count);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/req_pkg.sv
source/bank_pkg.sv
source/bank_router.sv
source/generic_queue.sv
source/rr_drain_arbiter.sv
source/bank_queue_top.sv
tb/bank_queue_tb.sv

/* Makefile */
TOP := bank_queue_tb

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --timing --top-module bank_queue_top -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
